// File: Bender.yml
package:
  name: sap_cpu

export_include_dirs:
  - common

sources:
  - common/sap_pkg.sv
  - verilog/sap_mem.sv
  - core/sap_control.sv
  - core/sap_datapath.sv
  - verilog/sap_out_port.sv
  - verilog/sap_cpu_top.sv
  - target: test
    files:
      - verification/sap_cpu_tb.sv

// File: common/sap_macros.svh
`ifndef SAP_MACROS_SVH
`define SAP_MACROS_SVH

// width of a memory address
// matches the operand nibble of every instruction
`define SAP_ADDR_W 4

// width of a data word and of the A and B registers
`define SAP_DATA_W 8

// number of bytes in the program memory
`define SAP_MEM_DEPTH 16

`endif

// File: common/sap_pkg.sv
`include "sap_macros.svh"

package sap_pkg;

    // one data word as held in memory and in the registers
    typedef logic [`SAP_DATA_W-1:0] byte_t;

    // memory address as held in the PC and MAR
    typedef logic [`SAP_ADDR_W-1:0] addr_t;

    // low half of an instruction, either an address or an immediate
    typedef logic [3:0] nibble_t;

    // upper nibble of an instruction
    // codes 9 to 13 are unused and run as NOP
    typedef enum logic [3:0] {
        OP_NOP = 4'h0,
        OP_LDA = 4'h1,
        OP_ADD = 4'h2,
        OP_SUB = 4'h3,
        OP_STA = 4'h4,
        OP_LDI = 4'h5,
        OP_JMP = 4'h6,
        OP_JC  = 4'h7,
        OP_JZ  = 4'h8,
        OP_OUT = 4'hE,
        OP_HLT = 4'hF
    } opcode_t;

    // micro-step of the instruction cycle
    // T1 and T2 fetch, T3 to T5 execute
    typedef enum logic [2:0] {
        TS_T1,
        TS_T2,
        TS_T3,
        TS_T4,
        TS_T5,
        TS_HALTED
    } tstate_t;

endpackage

// File: core/sap_control.sv
`default_nettype none
`timescale 1ns/1ps

module sap_control (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               run_i,
    input  wire sap_pkg::opcode_t   opcode_i,
    input  wire logic               carry_i,
    input  wire logic               zero_i,
    output      logic               mar_load_pc_o,
    output      logic               mar_load_ir_o,
    output      logic               ir_load_o,
    output      logic               pc_inc_o,
    output      logic               pc_load_o,
    output      logic               a_load_mem_o,
    output      logic               a_load_imm_o,
    output      logic               b_load_o,
    output      logic               alu_to_a_o,
    output      logic               ram_we_o,
    output      logic               out_load_o,
    output      logic               halted_o
);

sap_pkg::tstate_t state;
sap_pkg::tstate_t state_next;
logic             run_q;
logic             step;
logic             jump_taken;

// run level seen at the last rising edge
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        run_q <= 1'b0;
    end else begin
        run_q <= run_i;
    end
end

// the first edge after run_i rises is skipped
// memory may still have read the load address on that falling edge
assign step = run_i && run_q;

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state <= sap_pkg::TS_T1;
    end else begin
        state <= state_next;
    end
end

// next micro-step, held while paused and forever once halted
always_comb begin
    state_next = state;
    if (step) begin
        case (state)
            sap_pkg::TS_T1: state_next = sap_pkg::TS_T2;
            sap_pkg::TS_T2: state_next = sap_pkg::TS_T3;
            sap_pkg::TS_T3: begin
                if (opcode_i == sap_pkg::OP_HLT) begin
                    state_next = sap_pkg::TS_HALTED;
                end else begin
                    state_next = sap_pkg::TS_T4;
                end
            end
            sap_pkg::TS_T4: state_next = sap_pkg::TS_T5;
            sap_pkg::TS_T5: state_next = sap_pkg::TS_T1;
            default:        state_next = state;
        endcase
    end
end

// conditional jumps test the flags left by the last ADD or SUB
always_comb begin
    case (opcode_i)
        sap_pkg::OP_JMP: jump_taken = 1'b1;
        sap_pkg::OP_JC:  jump_taken = carry_i;
        sap_pkg::OP_JZ:  jump_taken = zero_i;
        default:         jump_taken = 1'b0;
    endcase
end

// micro-step decode
always_comb begin
    mar_load_pc_o = 1'b0;
    mar_load_ir_o = 1'b0;
    ir_load_o     = 1'b0;
    pc_inc_o      = 1'b0;
    pc_load_o     = 1'b0;
    a_load_mem_o  = 1'b0;
    a_load_imm_o  = 1'b0;
    b_load_o      = 1'b0;
    alu_to_a_o    = 1'b0;
    ram_we_o      = 1'b0;
    out_load_o    = 1'b0;
    if (step) begin
        case (state)
            // fetch address
            sap_pkg::TS_T1: mar_load_pc_o = 1'b1;
            // fetch instruction, point at the next one
            sap_pkg::TS_T2: begin
                ir_load_o = 1'b1;
                pc_inc_o  = 1'b1;
            end
            sap_pkg::TS_T3: begin
                case (opcode_i)
                    sap_pkg::OP_LDA, sap_pkg::OP_ADD, sap_pkg::OP_SUB, sap_pkg::OP_STA:
                        mar_load_ir_o = 1'b1;
                    sap_pkg::OP_LDI: a_load_imm_o = 1'b1;
                    sap_pkg::OP_JMP, sap_pkg::OP_JC, sap_pkg::OP_JZ:
                        pc_load_o = jump_taken;
                    sap_pkg::OP_OUT: out_load_o = 1'b1;
                    default: ;
                endcase
            end
            sap_pkg::TS_T4: begin
                case (opcode_i)
                    sap_pkg::OP_LDA:                  a_load_mem_o = 1'b1;
                    sap_pkg::OP_ADD, sap_pkg::OP_SUB: b_load_o     = 1'b1;
                    sap_pkg::OP_STA:                  ram_we_o     = 1'b1;
                    default: ;
                endcase
            end
            // result of ADD or SUB written back with the flags
            sap_pkg::TS_T5: begin
                alu_to_a_o = (opcode_i == sap_pkg::OP_ADD) || (opcode_i == sap_pkg::OP_SUB);
            end
            default: ;
        endcase
    end
end

assign halted_o = (state == sap_pkg::TS_HALTED);

// A has a single writer in any cycle
a_load_single: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    $onehot0({a_load_mem_o, a_load_imm_o, alu_to_a_o})
);

// halt is final and the datapath stays quiet afterwards
halt_is_final: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    halted_o |=> halted_o && !(|{mar_load_pc_o, mar_load_ir_o, ir_load_o, pc_inc_o,
                                 pc_load_o, a_load_mem_o, a_load_imm_o, b_load_o,
                                 alu_to_a_o, ram_we_o, out_load_o})
);

endmodule

`default_nettype wire

// File: core/sap_datapath.sv
`default_nettype none
`timescale 1ns/1ps

`include "sap_macros.svh"

module sap_datapath (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               mar_load_pc_i,
    input  wire logic               mar_load_ir_i,
    input  wire logic               ir_load_i,
    input  wire logic               pc_inc_i,
    input  wire logic               pc_load_i,
    input  wire logic               a_load_mem_i,
    input  wire logic               a_load_imm_i,
    input  wire logic               b_load_i,
    input  wire logic               alu_to_a_i,
    input  wire sap_pkg::byte_t     mem_rdata_i,
    output      sap_pkg::addr_t     mar_o,
    output      sap_pkg::byte_t     a_o,
    output      sap_pkg::opcode_t   opcode_o,
    output      logic               carry_o,
    output      logic               zero_o
);

sap_pkg::addr_t         pc;
sap_pkg::byte_t         ir;
sap_pkg::byte_t         b_reg;
sap_pkg::nibble_t       ir_operand;
sap_pkg::byte_t         b_operand;
logic                   sub_sel;
logic [`SAP_DATA_W:0]   alu_sum;

// instruction fields
assign opcode_o   = sap_pkg::opcode_t'(ir[7:4]);
assign ir_operand = ir[3:0];

// program counter
// a taken jump wins over the increment
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        pc <= '0;
    end else if (pc_load_i) begin
        pc <= ir_operand;
    end else if (pc_inc_i) begin
        pc <= pc + sap_pkg::addr_t'(1);
    end
end

// memory address register, from PC on fetch and from IR on execute
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        mar_o <= '0;
    end else if (mar_load_pc_i) begin
        mar_o <= pc;
    end else if (mar_load_ir_i) begin
        mar_o <= ir_operand;
    end
end

// instruction register
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        ir <= '0;
    end else if (ir_load_i) begin
        ir <= mem_rdata_i;
    end
end

// B holds the memory operand of ADD and SUB
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        b_reg <= '0;
    end else if (b_load_i) begin
        b_reg <= mem_rdata_i;
    end
end

// adder, SUB adds the two's complement of B
// carry out is then set when there is no borrow
assign sub_sel   = (opcode_o == sap_pkg::OP_SUB);
assign b_operand = sub_sel ? ~b_reg : b_reg;
assign alu_sum   = {1'b0, a_o} + {1'b0, b_operand} + {{`SAP_DATA_W{1'b0}}, sub_sel};

// accumulator
// LDI fills only the low nibble
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        a_o <= '0;
    end else if (a_load_mem_i) begin
        a_o <= mem_rdata_i;
    end else if (a_load_imm_i) begin
        a_o <= {4'h0, ir_operand};
    end else if (alu_to_a_i) begin
        a_o <= alu_sum[`SAP_DATA_W-1:0];
    end
end

// flags only move on an ALU write back
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        carry_o <= 1'b0;
        zero_o  <= 1'b0;
    end else if (alu_to_a_i) begin
        carry_o <= alu_sum[`SAP_DATA_W];
        zero_o  <= (alu_sum[`SAP_DATA_W-1:0] == '0);
    end
end

endmodule

`default_nettype wire

// File: sap_cpu.f
+incdir+common
common/sap_pkg.sv
verilog/sap_mem.sv
core/sap_control.sv
core/sap_datapath.sv
verilog/sap_out_port.sv
verilog/sap_cpu_top.sv
verification/sap_cpu_tb.sv

// File: verification/sap_cpu_tb.sv
`timescale 1ns/1ps

module sap_cpu_tb;

localparam int N_TESTS = 8;
localparam int MARGIN  = 2000;

logic           clk;
logic           rst_n_i;
logic           run_i;
logic           prog_we_i;
sap_pkg::addr_t prog_addr_i;
sap_pkg::byte_t prog_data_i;
sap_pkg::byte_t out_data_o;
logic           out_valid_o;
logic           halted_o;

// test table, one row per program
// program bytes packed with address 0 leftmost
string          test_name   [N_TESTS];
logic [127:0]   test_prog   [N_TESTS];
int             test_instrs [N_TESTS];
logic           test_halt   [N_TESTS];
logic           test_pause  [N_TESTS];
int             exp_first   [N_TESTS];
int             exp_count   [N_TESTS];
sap_pkg::byte_t exp_stream  [$];
sap_pkg::byte_t seen        [$];

int n_rows;
int errors;
int cycles;
int limit;
int seed;
int v;

sap_cpu_top sap_cpu_top_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .run_i       (run_i),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .out_data_o  (out_data_o),
    .out_valid_o (out_valid_o),
    .halted_o    (halted_o)
);

always #2 clk = ~clk;

// run limit over the whole table
always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
        $display("timeout: the CPU did not finish within %0d cycles", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end
end

task automatic add_test(input string name, input logic [127:0] prog, input int instrs,
                        input logic halt, input logic pause);
    test_name[n_rows]   = name;
    test_prog[n_rows]   = prog;
    test_instrs[n_rows] = instrs;
    test_halt[n_rows]   = halt;
    test_pause[n_rows]  = pause;
    exp_first[n_rows]   = exp_stream.size();
    exp_count[n_rows]   = 0;
    n_rows++;
endtask

// expected OUT value of the last added row
task automatic expect_out(input sap_pkg::byte_t value);
    exp_stream.push_back(value);
    exp_count[n_rows-1]++;
endtask

task automatic compare(input string what, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
        errors++;
        $display("FAILED %s expected %0h actual %0h", what, expected, actual);
    end
endtask

task automatic apply_reset;
    rst_n_i   <= 1'b0;
    run_i     <= 1'b0;
    prog_we_i <= 1'b0;
    repeat (16) @(negedge clk);
    rst_n_i <= 1'b1;
endtask

// one byte per cycle through the load port, run_i goes high with the last write
task automatic load_and_start(input int t);
    for (int a = 0; a < 16; a++) begin
        @(negedge clk);
        prog_we_i   <= 1'b1;
        prog_addr_i <= sap_pkg::addr_t'(a);
        prog_data_i <= test_prog[t][(15-a)*8 +: 8];
    end
    @(negedge clk);
    prog_we_i <= 1'b0;
    run_i     <= 1'b1;
endtask

task automatic run_test(input int t);
    int steps;
    int resumes;
    int hold;
    steps   = 0;
    resumes = 1;
    hold    = 0;
    seen.delete();
    apply_reset();
    // outputs right after reset
    compare({test_name[t], " reset out_data"}, 32'h0, out_data_o);
    compare({test_name[t], " reset out_valid"}, 32'h0, out_valid_o);
    compare({test_name[t], " reset halted"}, 32'h0, halted_o);
    load_and_start(t);
    // each instruction is five running edges, a resume costs one more
    while (!halted_o && steps < test_instrs[t] * 5 + 4 + resumes) begin
        @(negedge clk);
        if (run_i) begin
            steps++;
        end
        if (out_valid_o) begin
            seen.push_back(out_data_o);
        end
        if (hold > 0) begin
            hold--;
            if (hold == 0) begin
                run_i <= 1'b1;
                resumes++;
            end
        end else if (test_pause[t] && (($random(seed) & 7) == 0)) begin
            run_i <= 1'b0;
            hold = 1 + ($random(seed) & 7);
        end
    end
    // pulses after the halt would land here
    run_i <= 1'b1;
    repeat (12) begin
        @(negedge clk);
        if (out_valid_o) begin
            seen.push_back(out_data_o);
        end
    end
    compare({test_name[t], " halt"}, test_halt[t], halted_o);
    compare({test_name[t], " out count"}, exp_count[t], seen.size());
    for (int i = 0; i < exp_count[t] && i < seen.size(); i++) begin
        compare($sformatf("%s out %0d", test_name[t], i), exp_stream[exp_first[t] + i], seen[i]);
    end
endtask

initial begin
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    run_i       = 1'b0;
    prog_we_i   = 1'b0;
    prog_addr_i = '0;
    prog_data_i = '0;
    seed        = 32'h535041d2;
    errors      = 0;
    cycles      = 0;
    n_rows      = 0;
    limit       = MARGIN;

    // LDI fills the low nibble, LDA takes the whole byte
    add_test("load_out", 128'h57_E0_1E_E0_50_E0_1F_E0_F0_00_00_00_00_00_A5_3C, 9, 1'b1, 1'b0);
    expect_out(8'h07);
    expect_out(8'hA5);
    expect_out(8'h00);
    expect_out(8'h3C);
    // F0+20 wraps with carry, 10-20 borrows, F0-F0 gives zero
    add_test("add_sub_wrap", 128'h1E_2F_E0_3D_E0_3C_E0_F0_00_00_00_00_F0_20_F0_20, 8, 1'b1, 1'b0);
    expect_out(8'h10);
    expect_out(8'hF0);
    expect_out(8'h00);
    // 234 plus 4, then plus 1 until the carry ends the loop
    add_test("reference_count", 128'h1E_2F_E0_2D_76_62_F0_00_00_00_00_00_00_01_EA_04, 74, 1'b1, 1'b0);
    for (v = 8'hEE; v <= 8'hFF; v++) begin
        expect_out(v[7:0]);
    end
    // countdown with JZ, then JC taken after SUB and not taken after ADD
    add_test("cond_jumps", 128'h1F_E0_3E_85_61_77_E0_2D_7A_E0_F0_00_00_00_01_03, 17, 1'b1, 1'b0);
    expect_out(8'h03);
    expect_out(8'h02);
    expect_out(8'h01);
    expect_out(8'h00);
    // 09+30 stored to 14 and read back
    add_test("store_reload", 128'h59_2F_4E_50_1E_E0_F0_00_00_00_00_00_00_00_00_30, 7, 1'b1, 1'b0);
    expect_out(8'h39);
    // opcodes 9 to 13 fall through, the OUT after HLT never runs
    add_test("halt_nop", 128'h55_9F_AE_B3_C1_DF_0F_E0_F0_E0_56_E0_00_00_00_00, 9, 1'b1, 1'b0);
    expect_out(8'h05);
    // same counting program with random stops of run_i
    add_test("pause_count", 128'h1E_2F_E0_2D_76_62_F0_00_00_00_00_00_00_01_EA_04, 74, 1'b1, 1'b1);
    for (v = 8'hEE; v <= 8'hFF; v++) begin
        expect_out(v[7:0]);
    end
    add_test("pause_jumps", 128'h1F_E0_3E_85_61_77_E0_2D_7A_E0_F0_00_00_00_01_03, 17, 1'b1, 1'b1);
    expect_out(8'h03);
    expect_out(8'h02);
    expect_out(8'h01);
    expect_out(8'h00);

    // reset, load and drain per row, paused rows stretched up to ten times
    for (int t = 0; t < n_rows; t++) begin
        limit += 60 + test_instrs[t] * 5 * (test_pause[t] ? 10 : 1);
    end
    for (int t = 0; t < n_rows; t++) begin
        run_test(t);
    end

    $display("tests run %0d, errors %0d", n_rows, errors);
    if (errors == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
end

endmodule

// File: verilog/sap_cpu_top.sv
`default_nettype none
`timescale 1ns/1ps

module sap_cpu_top (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               run_i,
    input  wire logic               prog_we_i,
    input  wire sap_pkg::addr_t     prog_addr_i,
    input  wire sap_pkg::byte_t     prog_data_i,
    output      sap_pkg::byte_t     out_data_o,
    output      logic               out_valid_o,
    output      logic               halted_o
);

// control strobes
logic mar_load_pc;
logic mar_load_ir;
logic ir_load;
logic pc_inc;
logic pc_load;
logic a_load_mem;
logic a_load_imm;
logic b_load;
logic alu_to_a;
logic ram_we;
logic out_load;

// datapath state seen by control, memory and output
sap_pkg::opcode_t opcode;
logic             carry;
logic             zero;
sap_pkg::addr_t   mar;
sap_pkg::byte_t   a_value;
sap_pkg::byte_t   mem_rdata;

// program and data memory, STA writes the accumulator
sap_mem sap_mem_i (
    .clk         (clk),
    .run_i       (run_i),
    .cpu_we_i    (ram_we),
    .cpu_addr_i  (mar),
    .cpu_wdata_i (a_value),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .rdata_o     (mem_rdata)
);

sap_control sap_control_i (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .run_i         (run_i),
    .opcode_i      (opcode),
    .carry_i       (carry),
    .zero_i        (zero),
    .mar_load_pc_o (mar_load_pc),
    .mar_load_ir_o (mar_load_ir),
    .ir_load_o     (ir_load),
    .pc_inc_o      (pc_inc),
    .pc_load_o     (pc_load),
    .a_load_mem_o  (a_load_mem),
    .a_load_imm_o  (a_load_imm),
    .b_load_o      (b_load),
    .alu_to_a_o    (alu_to_a),
    .ram_we_o      (ram_we),
    .out_load_o    (out_load),
    .halted_o      (halted_o)
);

sap_datapath sap_datapath_i (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .mar_load_pc_i (mar_load_pc),
    .mar_load_ir_i (mar_load_ir),
    .ir_load_i     (ir_load),
    .pc_inc_i      (pc_inc),
    .pc_load_i     (pc_load),
    .a_load_mem_i  (a_load_mem),
    .a_load_imm_i  (a_load_imm),
    .b_load_i      (b_load),
    .alu_to_a_i    (alu_to_a),
    .mem_rdata_i   (mem_rdata),
    .mar_o         (mar),
    .a_o           (a_value),
    .opcode_o      (opcode),
    .carry_o       (carry),
    .zero_o        (zero)
);

sap_out_port sap_out_port_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .out_load_i  (out_load),
    .a_i         (a_value),
    .out_data_o  (out_data_o),
    .out_valid_o (out_valid_o)
);

endmodule

`default_nettype wire

// File: verilog/sap_mem.sv
`default_nettype none
`timescale 1ns/1ps

`include "sap_macros.svh"

module sap_mem (
    input  wire logic               clk,
    input  wire logic               run_i,
    input  wire logic               cpu_we_i,
    input  wire sap_pkg::addr_t     cpu_addr_i,
    input  wire sap_pkg::byte_t     cpu_wdata_i,
    input  wire logic               prog_we_i,
    input  wire sap_pkg::addr_t     prog_addr_i,
    input  wire sap_pkg::byte_t     prog_data_i,
    output      sap_pkg::byte_t     rdata_o
);

// 16 bytes shared by program and data
sap_pkg::byte_t memory [0:`SAP_MEM_DEPTH-1];

sap_pkg::addr_t mem_addr;
sap_pkg::byte_t mem_wdata;
logic           mem_we;

// cpu owns the port while running
// the load port owns it while stopped
assign mem_addr  = run_i ? cpu_addr_i  : prog_addr_i;
assign mem_wdata = run_i ? cpu_wdata_i : prog_data_i;
assign mem_we    = run_i ? cpu_we_i    : prog_we_i;

// falling edge write, so the MAR set on the rising edge has settled
always_ff @(negedge clk) begin
    if (mem_we) begin
        memory[mem_addr] <= mem_wdata;
    end
end

// read on the falling edge
// data is stable for the datapath at the next rising edge
always_ff @(negedge clk) begin
    rdata_o <= memory[mem_addr];
end

// program loading is only allowed with the cpu stopped
prog_load_while_stopped: assert property (
    @(negedge clk) !(run_i && prog_we_i)
) else $error("program write while the cpu is running");

endmodule

`default_nettype wire

// File: verilog/sap_out_port.sv
`default_nettype none
`timescale 1ns/1ps

module sap_out_port (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               out_load_i,
    input  wire sap_pkg::byte_t     a_i,
    output      sap_pkg::byte_t     out_data_o,
    output      logic               out_valid_o
);

// displayed value, kept until the next OUT
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        out_data_o <= '0;
    end else if (out_load_i) begin
        out_data_o <= a_i;
    end
end

// one pulse per OUT, aligned with the new value
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        out_valid_o <= 1'b0;
    end else begin
        out_valid_o <= out_load_i;
    end
end

// OUT pulses are at least one instruction apart
valid_single_cycle: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    out_valid_o |=> !out_valid_o
);

endmodule

`default_nettype wire
